// File: common/game_pkg.sv
package game_pkg;

    // widest level uses all pattern bits
    localparam int PAT_W = 7;
    localparam int LED_W = 16;

    typedef enum logic [1:0]
    {
        PH_IDLE  = 2'd0,
        PH_SHOW  = 2'd1,
        PH_GUESS = 2'd2,
        PH_WIN   = 2'd3
    } game_phase_e;

    typedef enum logic [1:0]
    {
        TONE_NONE = 2'd0,
        TONE_PASS = 2'd1,
        TONE_FAIL = 2'd2
    } tone_e;

    // level runs 1 to 3
    typedef struct packed
    {
        game_phase_e phase;
        logic [1:0]  level;
    } game_stat_t;

    // valid is a one-cycle strobe
    typedef struct packed
    {
        logic  valid;
        tone_e kind;
    } tone_req_t;

endpackage

// File: verilog/pattern_rng.sv
`timescale 1ns/1ps

module pattern_rng import game_pkg::*;
(
    input  logic             clk,
    input  logic             sw,
    input  logic             new_pat,
    output logic [PAT_W-1:0] pattern
);

    localparam logic [15:0] SEED = 16'hace1;

    logic [15:0] lfsr;
    logic        feedback;

    // x^16 + x^14 + x^13 + x^11 + 1
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // free running, so the draw depends on when start comes
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            lfsr <= SEED;
        end
        else
        begin
            lfsr <= {lfsr[14:0], feedback};
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            pattern <= '0;
        end
        else if (new_pat)
        begin
            pattern <= lfsr[PAT_W-1:0];
        end
    end

endmodule

// File: verilog/countdown_timer.sv
`timescale 1ns/1ps

module countdown_timer
#(
    parameter int COUNT_CYCLES = 100
)
(
    input  logic                                 clk,
    input  logic                                 sw,
    input  logic                                 load,
    output logic                                 done,
    output logic [$clog2(COUNT_CYCLES+1)-1:0]    remaining
);

    localparam int CNT_W = $clog2(COUNT_CYCLES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            count <= '0;
        end
        else if (load)
        begin
            // a reload restarts a running count
            count <= CNT_W'(COUNT_CYCLES);
        end
        else if (count != '0)
        begin
            count <= count - 1'b1;
        end
    end

    // high in the last counting cycle, so the phase moves on
    // exactly as the count hits zero
    assign done = (count == CNT_W'(1)) && !load;

    assign remaining = count;

endmodule

// File: verilog/tone_gen.sv
`timescale 1ns/1ps

module tone_gen import game_pkg::*;
#(
    parameter int BEEP_CYCLES = 1000,
    parameter int TONE_DIV    = 10
)
(
    input  logic      clk,
    input  logic      sw,
    input  tone_req_t tone_req,
    output logic      beep
);

    localparam int DUR_W  = $clog2(BEEP_CYCLES + 1);
    localparam int HALF_W = $clog2(2 * TONE_DIV + 1);

    logic [DUR_W-1:0]  dur_cnt;
    logic [HALF_W-1:0] div_cnt;
    logic [HALF_W-1:0] half;
    logic [HALF_W-1:0] half_req;

    // fail tone sounds an octave lower
    assign half_req = (tone_req.kind == TONE_FAIL) ? HALF_W'(2 * TONE_DIV)
                                                   : HALF_W'(TONE_DIV);

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            dur_cnt <= '0;
            div_cnt <= '0;
            half    <= '0;
            beep    <= 1'b0;
        end
        else if (tone_req.valid && tone_req.kind != TONE_NONE)
        begin
            // restart, first half-period high
            dur_cnt <= DUR_W'(BEEP_CYCLES);
            half    <= half_req;
            div_cnt <= half_req - 1'b1;
            beep    <= 1'b1;
        end
        else if (tone_req.valid)
        begin
            dur_cnt <= '0;
            beep    <= 1'b0;
        end
        else if (dur_cnt != '0)
        begin
            dur_cnt <= dur_cnt - 1'b1;
            if (dur_cnt == DUR_W'(1))
            begin
                beep <= 1'b0;
            end
            else if (div_cnt == '0)
            begin
                beep    <= ~beep;
                div_cnt <= half - 1'b1;
            end
            else
            begin
                div_cnt <= div_cnt - 1'b1;
            end
        end
    end

endmodule

// File: verilog/seg_scan.sv
`timescale 1ns/1ps

module seg_scan import game_pkg::*;
#(
    parameter int SCAN_DIV = 1000,
    parameter int CNT_W    = 8
)
(
    input  logic             clk,
    input  logic             sw,
    input  game_stat_t       status,
    input  logic [CNT_W-1:0] remaining,
    output logic [7:0]       seg,
    output logic [7:0]       dig
);

    localparam int PRE_W = $clog2(SCAN_DIV + 1);

    logic [PRE_W-1:0]   pre;
    logic [2:0]         idx;
    logic [CNT_W+7:0]   rem_ext;
    logic [7:0]         rem_byte;

    // segments are {dp,g,f,e,d,c,b,a}, active high
    function automatic logic [7:0] hex_seg(input logic [3:0] val);
        case (val)
            4'h0: hex_seg = 8'h3f;
            4'h1: hex_seg = 8'h06;
            4'h2: hex_seg = 8'h5b;
            4'h3: hex_seg = 8'h4f;
            4'h4: hex_seg = 8'h66;
            4'h5: hex_seg = 8'h6d;
            4'h6: hex_seg = 8'h7d;
            4'h7: hex_seg = 8'h07;
            4'h8: hex_seg = 8'h7f;
            4'h9: hex_seg = 8'h6f;
            4'ha: hex_seg = 8'h77;
            4'hb: hex_seg = 8'h7c;
            4'hc: hex_seg = 8'h39;
            4'hd: hex_seg = 8'h5e;
            4'he: hex_seg = 8'h79;
            default: hex_seg = 8'h71;
        endcase
    endfunction

    // dash, S, G and P for pass
    function automatic logic [7:0] phase_seg(input game_phase_e ph);
        case (ph)
            PH_SHOW:  phase_seg = 8'h6d;
            PH_GUESS: phase_seg = 8'h3d;
            PH_WIN:   phase_seg = 8'h73;
            default:  phase_seg = 8'h40;
        endcase
    endfunction

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            pre <= '0;
            idx <= '0;
        end
        else if (pre == PRE_W'(SCAN_DIV - 1))
        begin
            pre <= '0;
            idx <= idx + 1'b1;
        end
        else
        begin
            pre <= pre + 1'b1;
        end
    end

    assign rem_ext  = {8'h00, remaining};
    assign rem_byte = rem_ext[7:0];

    assign dig = ~(8'b0000_0001 << idx);

    always_comb
    begin
        case (idx)
            3'd0:    seg = hex_seg({2'b00, status.level});
            3'd1:    seg = phase_seg(status.phase);
            3'd2:    seg = hex_seg(rem_byte[7:4]);
            3'd3:    seg = hex_seg(rem_byte[3:0]);
            default: seg = 8'h00;
        endcase
    end

endmodule

// File: game_ctrl/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl import game_pkg::*;
(
    input  logic             clk,
    input  logic             sw,
    input  logic             start,
    input  logic             submit,
    input  logic [PAT_W-1:0] guess,
    input  logic [PAT_W-1:0] pattern,
    input  logic             done,
    output logic             new_pat,
    output logic             load,
    output tone_req_t        tone_req,
    output game_stat_t       status,
    output logic [LED_W-1:0] led
);

    game_phase_e      phase;
    game_phase_e      phase_d;
    logic [1:0]       level;
    logic [1:0]       level_d;
    logic             new_pat_d;
    logic             load_d;
    tone_req_t        tone_d;
    logic [LED_W-1:0] led_d;
    logic             match;

    // level 1 keeps 5 bits, level 3 all of them
    function automatic logic [PAT_W-1:0] level_mask(input logic [1:0] lvl);
        logic [PAT_W-1:0] m;
        for (int i = 0; i < PAT_W; i++)
        begin
            m[i] = (i < PAT_W - 3 + int'(lvl));
        end
        return m;
    endfunction

    assign match = ((guess ^ pattern) & level_mask(level)) == '0;

    // next state and the registered outputs that go with it
    always_comb
    begin
        phase_d   = phase;
        level_d   = level;
        new_pat_d = 1'b0;
        load_d    = 1'b0;
        tone_d    = '{valid: 1'b0, kind: TONE_NONE};

        if (start)
        begin
            phase_d   = PH_SHOW;
            level_d   = 2'd1;
            new_pat_d = 1'b1;
            load_d    = 1'b1;
        end
        else
        begin
            case (phase)
                PH_SHOW:
                begin
                    if (done)
                    begin
                        phase_d = PH_GUESS;
                    end
                end
                PH_GUESS:
                begin
                    if (submit && match)
                    begin
                        tone_d = '{valid: 1'b1, kind: TONE_PASS};
                        if (level == 2'd3)
                        begin
                            phase_d = PH_WIN;
                        end
                        else
                        begin
                            phase_d = PH_SHOW;
                            level_d = level + 1'b1;
                            load_d  = 1'b1;
                        end
                    end
                    else if (submit)
                    begin
                        // same pattern again at the same level
                        tone_d  = '{valid: 1'b1, kind: TONE_FAIL};
                        phase_d = PH_SHOW;
                        load_d  = 1'b1;
                    end
                end
                default:
                begin
                end
            endcase
        end
    end

    // timer loads on the same edge that enters SHOW
    assign load = load_d;

    // dark until the new pattern has been captured
    always_comb
    begin
        case (phase_d)
            PH_SHOW:
            begin
                if (start || new_pat)
                begin
                    led_d = '0;
                end
                else
                begin
                    led_d = {{(LED_W - PAT_W){1'b0}}, pattern & level_mask(level_d)};
                end
            end
            PH_WIN:  led_d = '1;
            default: led_d = '0;
        endcase
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            phase    <= PH_IDLE;
            level    <= 2'd1;
            new_pat  <= 1'b0;
            tone_req <= '{valid: 1'b0, kind: TONE_NONE};
            led      <= '0;
        end
        else
        begin
            phase    <= phase_d;
            level    <= level_d;
            new_pat  <= new_pat_d;
            tone_req <= tone_d;
            led      <= led_d;
        end
    end

    assign status = '{phase: phase, level: level};

endmodule

// File: verilog/memory_game_top.sv
`timescale 1ns/1ps

module memory_game_top import game_pkg::*;
#(
    parameter int COUNT_CYCLES = 100_000_000,
    parameter int BEEP_CYCLES  = 10_000_000,
    parameter int TONE_DIV     = 25_000,
    parameter int SCAN_DIV     = 50_000
)
(
    input  logic             clk,
    input  logic             sw,
    input  logic             start,
    input  logic             submit,
    input  logic [PAT_W-1:0] guess,
    output logic [LED_W-1:0] led,
    output logic [7:0]       seg,
    output logic [7:0]       dig,
    output logic             beep,
    output game_stat_t       status
);

    localparam int CNT_W = $clog2(COUNT_CYCLES + 1);

    logic             new_pat;
    logic [PAT_W-1:0] pattern;
    logic             load;
    logic             done;
    logic [CNT_W-1:0] remaining;
    tone_req_t        tone_req;

    game_ctrl u_ctrl
    (
        .clk      (clk),
        .sw       (sw),
        .start    (start),
        .submit   (submit),
        .guess    (guess),
        .pattern  (pattern),
        .done     (done),
        .new_pat  (new_pat),
        .load     (load),
        .tone_req (tone_req),
        .status   (status),
        .led      (led)
    );

    pattern_rng u_rng
    (
        .clk     (clk),
        .sw      (sw),
        .new_pat (new_pat),
        .pattern (pattern)
    );

    countdown_timer #(.COUNT_CYCLES(COUNT_CYCLES)) u_timer
    (
        .clk       (clk),
        .sw        (sw),
        .load      (load),
        .done      (done),
        .remaining (remaining)
    );

    tone_gen #(.BEEP_CYCLES(BEEP_CYCLES), .TONE_DIV(TONE_DIV)) u_tone
    (
        .clk      (clk),
        .sw       (sw),
        .tone_req (tone_req),
        .beep     (beep)
    );

    seg_scan #(.SCAN_DIV(SCAN_DIV), .CNT_W(CNT_W)) u_scan
    (
        .clk       (clk),
        .sw        (sw),
        .status    (status),
        .remaining (remaining),
        .seg       (seg),
        .dig       (dig)
    );

endmodule

// File: sim/game_checker.sv
`timescale 1ns/1ps

module game_checker import game_pkg::*;
(
    input logic             clk,
    input logic             sw,
    input logic [LED_W-1:0] led,
    input logic [7:0]       dig,
    input logic             beep,
    input game_stat_t       status
);

    int fail_count = 0;

    // LEDs stay dark while the player enters a guess
    led_dark_in_guess: assert property (@(posedge clk) disable iff (sw)
        status.phase == PH_GUESS |-> led == '0)
    else
    begin
        $error("led is not dark in GUESS");
        fail_count = fail_count + 1;
    end

    one_digit_active: assert property (@(posedge clk) disable iff (sw)
        $onehot(~dig))
    else
    begin
        $error("dig does not have exactly one active digit");
        fail_count = fail_count + 1;
    end

    // no judgment has happened yet in IDLE
    quiet_in_idle: assert property (@(posedge clk) disable iff (sw)
        status.phase == PH_IDLE |-> !beep)
    else
    begin
        $error("beep is active in IDLE");
        fail_count = fail_count + 1;
    end

endmodule

bind memory_game_top game_checker u_checker
(
    .clk    (clk),
    .sw     (sw),
    .led    (led),
    .dig    (dig),
    .beep   (beep),
    .status (status)
);

// File: sim/tb_memory_game.sv
`timescale 1ns/1ps

module tb_memory_game import game_pkg::*;
;

    localparam int COUNT_CYCLES    = 20;
    localparam int BEEP_CYCLES     = 16;
    localparam int TONE_DIV        = 2;
    localparam int SCAN_DIV        = 3;
    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int N_TESTS         = 7;
    localparam int CYCLES_PER_TEST = 200;

    logic             clk;
    logic             sw;
    logic             start;
    logic             submit;
    logic [PAT_W-1:0] guess;
    logic [LED_W-1:0] led;
    logic [7:0]       seg;
    logic [7:0]       dig;
    logic             beep;
    game_stat_t       status;

    int               errors;
    logic [31:0]      lfsr_state;
    // pattern bits the player has seen so far
    logic [PAT_W-1:0] known;

    memory_game_top
    #(
        .COUNT_CYCLES (COUNT_CYCLES),
        .BEEP_CYCLES  (BEEP_CYCLES),
        .TONE_DIV     (TONE_DIV),
        .SCAN_DIV     (SCAN_DIV)
    )
    u_dut
    (
        .clk    (clk),
        .sw     (sw),
        .start  (start),
        .submit (submit),
        .guess  (guess),
        .led    (led),
        .seg    (seg),
        .dig    (dig),
        .beep   (beep),
        .status (status)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #((N_TESTS * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout, the directed tests did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    function automatic logic [31:0] low_mask(input int width);
        return (32'd1 << width) - 32'd1;
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // segments {dp,g,f,e,d,c,b,a} for GUESS at level 2 with the count run out
    function automatic logic [7:0] expected_seg(input logic [7:0] d);
        case (d)
            8'hfe:   return 8'h5b;
            8'hfd:   return 8'h3d;
            8'hfb:   return 8'h3f;
            8'hf7:   return 8'h3f;
            default: return 8'h00;
        endcase
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic pulse_submit(input logic [PAT_W-1:0] value);
        guess  = value;
        submit = 1'b1;
        @(negedge clk);
        submit = 1'b0;
    endtask

    task automatic check_phase(input game_phase_e ph, input int lvl);
        check_eq("status.phase", 32'(status.phase), 32'(ph));
        check_eq("status.level", 32'(status.level), 32'(lvl));
    endtask

    task automatic wait_phase(input game_phase_e target, output int cycles);
        cycles = 0;
        while (status.phase != target && cycles < CYCLES_PER_TEST)
        begin
            @(negedge clk);
            cycles++;
        end
        if (status.phase != target)
        begin
            $display("phase %0d was not reached within %0d cycles", target, CYCLES_PER_TEST);
            errors++;
        end
    endtask

    // width of the first high run of beep and of the low run after it
    task automatic measure_beep(output int high_w, output int low_w);
        logic samples[$];
        int   i;
        for (int n = 0; n < BEEP_CYCLES + 4; n++)
        begin
            @(negedge clk);
            samples.push_back(beep);
        end
        high_w = 0;
        low_w  = 0;
        i      = 0;
        while (i < samples.size() && samples[i] !== 1'b1)
        begin
            i++;
        end
        while (i < samples.size() && samples[i] === 1'b1)
        begin
            high_w++;
            i++;
        end
        while (i < samples.size() && samples[i] === 1'b0)
        begin
            low_w++;
            i++;
        end
    endtask

    task automatic test_reset_state();
        check_eq("status.phase", 32'(status.phase), 32'(PH_IDLE));
        check_eq("led", 32'(led), 0);
        check_eq("beep", 32'(beep), 0);
        check_eq("dig", 32'(dig), 32'h0000_00fe);
    endtask

    task automatic test_idle_submit();
        pulse_submit(7'h7f);
        check_eq("status.phase", 32'(status.phase), 32'(PH_IDLE));
        check_eq("led", 32'(led), 0);
    endtask

    task automatic start_game();
        int cycles;
        pulse_start();
        check_phase(PH_SHOW, 1);
        // new pattern reaches led two cycles after the strobe
        repeat (2) @(negedge clk);
        check_eq("led upper bits", 32'(led) & ~low_mask(5), 0);
        known = led[PAT_W-1:0];
        wait_phase(PH_GUESS, cycles);
        // two cycles of SHOW had passed before the wait
        check_eq("show cycles", 32'(cycles + 2), 32'(COUNT_CYCLES));
        check_eq("led", 32'(led), 0);
    endtask

    task automatic test_correct_guesses();
        int               high_w;
        int               low_w;
        int               cycles;
        logic [LED_W-1:0] shown;
        for (int lvl = 1; lvl <= 3; lvl++)
        begin
            pulse_submit(known);
            if (lvl < 3)
            begin
                check_phase(PH_SHOW, lvl + 1);
                shown = led;
                check_eq("led seen bits", 32'(shown) & low_mask(lvl + 4),
                         32'(known) & low_mask(lvl + 4));
                check_eq("led upper bits", 32'(shown) & ~low_mask(lvl + 5), 0);
                known = shown[PAT_W-1:0];
            end
            else
            begin
                check_phase(PH_WIN, 3);
                check_eq("led", 32'(led), 32'h0000_ffff);
            end
            measure_beep(high_w, low_w);
            check_eq("beep high width", 32'(high_w), 32'(TONE_DIV));
            check_eq("beep low width", 32'(low_w), 32'(TONE_DIV));
            if (lvl < 3)
            begin
                wait_phase(PH_GUESS, cycles);
            end
        end
    endtask

    task automatic test_restart();
        int cycles;
        check_eq("status.phase", 32'(status.phase), 32'(PH_WIN));
        pulse_start();
        check_phase(PH_SHOW, 1);
        pulse_submit('0);
        check_phase(PH_SHOW, 1);
        wait_phase(PH_GUESS, cycles);
        pulse_start();
        check_phase(PH_SHOW, 1);
    endtask

    task automatic test_wrong_guess();
        int               cycles;
        int               flip;
        int               high_w;
        int               low_w;
        logic [31:0]      r;
        logic [PAT_W-1:0] wrong;
        start_game();
        pulse_submit(known);
        check_phase(PH_SHOW, 2);
        known = led[PAT_W-1:0];
        wait_phase(PH_GUESS, cycles);
        // flip one bit inside the 6-bit mask, bit 6 is a don't care
        rand_bits(3, r);
        flip = int'(r % 32'd6);
        wrong = known ^ PAT_W'(32'd1 << flip);
        rand_bits(1, r);
        wrong[6] = r[0];
        pulse_submit(wrong);
        check_phase(PH_SHOW, 2);
        check_eq("led", 32'(led), 32'(known));
        measure_beep(high_w, low_w);
        check_eq("beep high width", 32'(high_w), 32'(2 * TONE_DIV));
        check_eq("beep low width", 32'(low_w), 32'(2 * TONE_DIV));
        wait_phase(PH_GUESS, cycles);
    endtask

    task automatic test_display_scan();
        logic [7:0] prev;
        logic [7:0] seen;
        int         run;
        int         guard;
        check_phase(PH_GUESS, 2);
        prev  = dig;
        guard = 0;
        while (dig == prev && guard < 2 * SCAN_DIV)
        begin
            @(negedge clk);
            guard++;
        end
        if (dig == prev)
        begin
            $display("dig did not move to another digit");
            errors++;
        end
        seen = '0;
        run  = 0;
        prev = dig;
        for (int n = 0; n < 8 * SCAN_DIV; n++)
        begin
            seen = seen | ~dig;
            check_eq("seg", 32'(seg), 32'(expected_seg(dig)));
            run++;
            @(negedge clk);
            if (dig != prev)
            begin
                check_eq("dig run length", 32'(run), 32'(SCAN_DIV));
                check_eq("dig", 32'(dig), 32'({prev[6:0], prev[7]}));
                run  = 0;
                prev = dig;
            end
        end
        check_eq("dig digits seen", 32'(seen), 32'h0000_00ff);
    endtask

    initial
    begin
        errors     = 0;
        lfsr_state = 32'haeeecc2c;
        known      = '0;
        sw         = 1'b1;
        start      = 1'b0;
        submit     = 1'b0;
        guess      = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        sw = 1'b0;

        test_reset_state();
        test_idle_submit();
        start_game();
        test_correct_guesses();
        test_restart();
        test_wrong_guess();
        test_display_scan();

        $display("errors: %0d, assertion failures: %0d", errors, u_dut.u_checker.fail_count);
        if (errors == 0 && u_dut.u_checker.fail_count == 0)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
common/game_pkg.sv
verilog/pattern_rng.sv
verilog/countdown_timer.sv
verilog/tone_gen.sv
verilog/seg_scan.sv
game_ctrl/game_ctrl.sv
verilog/memory_game_top.sv
sim/game_checker.sv
sim/tb_memory_game.sv

// File: Makefile
TOP := tb_memory_game

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | \
		awk '{print} /Simulation finished: PASS/ {ok = 1} END {exit !ok}'

clean:
	rm -rf obj_dir
